// ==== stu_pkg.sv ====
/*
  shared widths, encodings and beat structs for the upstream stack-bus receiver
  referenced by scoped name from every receiver module
*/
package stu_pkg;

  // ------------------------------
  // widths and sizing
  localparam int STU_DATA_W     = 64;
  localparam int STU_OOB_W      = 32;
  localparam int STU_TAG_W      = 8;  // low bits of oob
  localparam int STU_FIFO_DEPTH = 8;
  localparam int STU_FIFO_SLACK = 3;  // beats still in flight behind registered ready

  // ------------------------------
  // encodings
  typedef enum logic [1:0] {
    SOM     = 2'd0,
    MOM     = 2'd1,
    EOM     = 2'd2,
    SOM_EOM = 2'd3
  } stu_cntl_e;

  typedef enum logic {
    CONTROL = 1'b0,
    DATA    = 1'b1
  } stu_type_e;

  typedef enum logic {
    DEST_RDP = 1'b0,  // return data processor
    DEST_RCP = 1'b1   // return control processor
  } stu_dest_e;

  typedef enum logic [2:0] {
    WAIT,
    CONTROL_SOM,
    CONTROL_MOM,
    CONTROL_COMPLETE,
    DATA_SOM,
    DATA_MOM,
    DATA_COMPLETE,
    ERR
  } stu_state_e;

  // ------------------------------
  // beats
  typedef struct packed {
    stu_cntl_e              cntl;
    stu_type_e              ptype;
    logic [STU_DATA_W-1:0]  data;
    logic [STU_OOB_W-1:0]   oob;
  } stu_beat_t;  // 99 bits

  typedef struct packed {
    stu_cntl_e              cntl;
    logic [STU_TAG_W-1:0]   tag;
    logic [STU_DATA_W-1:0]  data;
  } stu_out_t;  // 74 bits

endpackage

// ==== stu_rx_fifo.sv ====
/*
  input register and beat FIFO for the upstream stack bus
  ready toward the stack is registered from the almost-full level
*/
module stu_rx_fifo (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              stu_valid,
  input  stu_pkg::stu_beat_t stu_beat,
  output logic              stu_ready,
  input  logic              fifo_read,
  output logic              fifo_empty,
  output stu_pkg::stu_beat_t fifo_beat
);

  logic                                          in_valid;
  stu_pkg::stu_beat_t                            in_beat;
  stu_pkg::stu_beat_t                            mem [stu_pkg::STU_FIFO_DEPTH];
  logic [$clog2(stu_pkg::STU_FIFO_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(stu_pkg::STU_FIFO_DEPTH)-1:0]   rd_ptr;
  logic [$clog2(stu_pkg::STU_FIFO_DEPTH+1)-1:0] count;
  logic                                          almost_full;

  // ------------------------------
  // input register
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      in_valid <= 1'b0;
    else
      in_valid <= stu_valid;
  end

  always_ff @(posedge clk)
  begin
    in_beat <= stu_beat;  // payload only, qualified by in_valid
  end

  // ------------------------------
  // circular buffer
  always_ff @(posedge clk)
  begin
    if (in_valid)
      mem[wr_ptr] <= in_beat;
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (in_valid)
        wr_ptr <= (int'(wr_ptr) == stu_pkg::STU_FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      if (fifo_read)
        rd_ptr <= (int'(rd_ptr) == stu_pkg::STU_FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      case ({in_valid, fifo_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

  assign fifo_empty = (count == '0);
  assign fifo_beat  = mem[rd_ptr];

  // free entries at or below the slack
  assign almost_full = (int'(count) >= stu_pkg::STU_FIFO_DEPTH - stu_pkg::STU_FIFO_SLACK);

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      stu_ready <= 1'b0;  // stack waits until first rise
    else
      stu_ready <= ~almost_full;
  end

endmodule

// ==== stu_rx_pipe.sv ====
/*
  two-stage pipeline behind the beat FIFO
  reads ahead so the framing FSM always sees a charged head beat
*/
module stu_rx_pipe (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               fifo_empty,
  output logic               fifo_read,
  input  stu_pkg::stu_beat_t fifo_beat,
  input  logic               pipe_read,
  output logic               pipe_valid,
  output stu_pkg::stu_beat_t pipe_beat
);

  logic               fo_valid;  // fifo output stage
  stu_pkg::stu_beat_t fo_beat;
  logic               fo_read;

  // advance whenever the next stage is empty or draining
  assign fifo_read = ~fifo_empty & (~fo_valid | fo_read);
  assign fo_read   = fo_valid & (~pipe_valid | pipe_read);

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      fo_valid   <= 1'b0;
      pipe_valid <= 1'b0;
    end
    else
    begin
      if (fifo_read)
        fo_valid <= 1'b1;
      else if (fo_read)
        fo_valid <= 1'b0;

      if (fo_read)
        pipe_valid <= 1'b1;
      else if (pipe_read)
        pipe_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (fifo_read)
      fo_beat <= fifo_beat;
    if (fo_read)
      pipe_beat <= fo_beat;
  end

endmodule

// ==== stu_pkt_fsm.sv ====
/*
  framing FSM for upstream packets
  decides per head beat whether to consume it, forward it, and to which port
*/
module stu_pkt_fsm (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               pipe_valid,
  input  stu_pkg::stu_beat_t pipe_beat,
  input  logic               rdp_ready,
  input  logic               rcp_ready,
  output logic               pipe_read,
  output logic               fwd,
  output stu_pkg::stu_dest_e dest,
  output logic               rx_error
);

  stu_pkg::stu_state_e state;
  stu_pkg::stu_state_e state_nxt;
  logic                is_start;  // SOM or SOM_EOM
  logic                is_data;
  logic                port_rdy;

  assign is_start = (pipe_beat.cntl == stu_pkg::SOM) || (pipe_beat.cntl == stu_pkg::SOM_EOM);
  assign is_data  = (pipe_beat.ptype == stu_pkg::DATA);

  always_comb
  begin
    state_nxt = state;
    pipe_read = 1'b0;
    fwd       = 1'b0;
    dest      = is_data ? stu_pkg::DEST_RDP : stu_pkg::DEST_RCP;
    case (state)
      stu_pkg::CONTROL_SOM, stu_pkg::CONTROL_MOM:
        dest = stu_pkg::DEST_RCP;  // stay on the open packet's port
      stu_pkg::DATA_SOM, stu_pkg::DATA_MOM:
        dest = stu_pkg::DEST_RDP;
      default:
        ;
    endcase
    port_rdy = (dest == stu_pkg::DEST_RDP) ? rdp_ready : rcp_ready;

    case (state)
      stu_pkg::WAIT, stu_pkg::CONTROL_COMPLETE, stu_pkg::DATA_COMPLETE:
      begin
        if (pipe_valid && !is_start)
        begin
          pipe_read = 1'b1;  // drop it, framing broken
          state_nxt = stu_pkg::ERR;
        end
        else if (pipe_valid && port_rdy)
        begin
          pipe_read = 1'b1;
          fwd       = 1'b1;
          if (pipe_beat.cntl == stu_pkg::SOM)
            state_nxt = is_data ? stu_pkg::DATA_SOM : stu_pkg::CONTROL_SOM;
          else
            state_nxt = is_data ? stu_pkg::DATA_COMPLETE : stu_pkg::CONTROL_COMPLETE;
        end
      end
      stu_pkg::CONTROL_SOM, stu_pkg::CONTROL_MOM, stu_pkg::DATA_SOM, stu_pkg::DATA_MOM:
      begin
        if (pipe_valid && is_start)
        begin
          pipe_read = 1'b1;  // new start inside a packet
          state_nxt = stu_pkg::ERR;
        end
        else if (pipe_valid && port_rdy)
        begin
          pipe_read = 1'b1;
          fwd       = 1'b1;
          if (pipe_beat.cntl == stu_pkg::MOM)
            state_nxt = (dest == stu_pkg::DEST_RDP) ? stu_pkg::DATA_MOM : stu_pkg::CONTROL_MOM;
          else
            state_nxt = (dest == stu_pkg::DEST_RDP) ? stu_pkg::DATA_COMPLETE
                                                    : stu_pkg::CONTROL_COMPLETE;
        end
      end
      default:
        state_nxt = stu_pkg::ERR;  // held until reset
    endcase
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      state <= stu_pkg::WAIT;
    else if (pipe_read)
      state <= state_nxt;
  end

  assign rx_error = (state == stu_pkg::ERR);

endmodule

// ==== stu_out_stage.sv ====
/*
  registered outputs toward the return data and return control processors
  loads whichever port the FSM selects and slices the tag from oob
*/
module stu_out_stage (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               fwd,
  input  stu_pkg::stu_dest_e dest,
  input  stu_pkg::stu_beat_t pipe_beat,
  output logic               rdp_valid,
  output logic               rcp_valid,
  output stu_pkg::stu_out_t  rdp,
  output stu_pkg::stu_out_t  rcp
);

  stu_pkg::stu_out_t out_beat;
  logic              load_rdp;
  logic              load_rcp;

  // tag comes from the low oob bits
  assign out_beat.cntl = pipe_beat.cntl;
  assign out_beat.tag  = pipe_beat.oob[stu_pkg::STU_TAG_W-1:0];
  assign out_beat.data = pipe_beat.data;

  assign load_rdp = fwd && (dest == stu_pkg::DEST_RDP);
  assign load_rcp = fwd && (dest == stu_pkg::DEST_RCP);

  // ------------------------------
  // one-cycle valid pulses
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      rdp_valid <= 1'b0;
      rcp_valid <= 1'b0;
    end
    else
    begin
      rdp_valid <= load_rdp;
      rcp_valid <= load_rcp;
    end
  end

  // payloads hold between beats
  always_ff @(posedge clk)
  begin
    if (load_rdp)
      rdp <= out_beat;
    if (load_rcp)
      rcp <= out_beat;
  end

endmodule

// ==== stu_cntl.sv ====
/*
  upstream stack-bus receiver top level
  buffers stack beats, checks framing and routes packets to the rdp and rcp ports
*/
module stu_cntl (
  input  logic               clk,
  input  logic               arst_n,

  // stack bus, upstream
  input  logic               stu_valid,
  input  stu_pkg::stu_beat_t stu_beat,
  output logic               stu_ready,

  // return data processor
  output logic               rdp_valid,
  output stu_pkg::stu_out_t  rdp,
  input  logic               rdp_ready,

  // return control processor
  output logic               rcp_valid,
  output stu_pkg::stu_out_t  rcp,
  input  logic               rcp_ready,

  output logic               rx_error  // sticky framing error
);

  logic               fifo_empty;
  logic               fifo_read;
  stu_pkg::stu_beat_t fifo_beat;
  logic               pipe_valid;
  logic               pipe_read;
  stu_pkg::stu_beat_t pipe_beat;
  logic               fwd;
  stu_pkg::stu_dest_e dest;

  stu_rx_fifo u_rx_fifo (
    .clk        (clk),
    .arst_n     (arst_n),
    .stu_valid  (stu_valid),
    .stu_beat   (stu_beat),
    .stu_ready  (stu_ready),
    .fifo_read  (fifo_read),
    .fifo_empty (fifo_empty),
    .fifo_beat  (fifo_beat)
  );

  stu_rx_pipe u_rx_pipe (
    .clk        (clk),
    .arst_n     (arst_n),
    .fifo_empty (fifo_empty),
    .fifo_read  (fifo_read),
    .fifo_beat  (fifo_beat),
    .pipe_read  (pipe_read),
    .pipe_valid (pipe_valid),
    .pipe_beat  (pipe_beat)
  );

  stu_pkt_fsm u_pkt_fsm (
    .clk        (clk),
    .arst_n     (arst_n),
    .pipe_valid (pipe_valid),
    .pipe_beat  (pipe_beat),
    .rdp_ready  (rdp_ready),
    .rcp_ready  (rcp_ready),
    .pipe_read  (pipe_read),
    .fwd        (fwd),
    .dest       (dest),
    .rx_error   (rx_error)
  );

  stu_out_stage u_out_stage (
    .clk        (clk),
    .arst_n     (arst_n),
    .fwd        (fwd),
    .dest       (dest),
    .pipe_beat  (pipe_beat),
    .rdp_valid  (rdp_valid),
    .rcp_valid  (rcp_valid),
    .rdp        (rdp),
    .rcp        (rcp)
  );

endmodule

// ==== tb_stu_cntl.sv ====
/*
  testbench for the upstream stack-bus receiver
  random framed packets, per-port scoreboards, back-pressure and framing error checks
*/
module tb_stu_cntl;

  typedef enum {RDY_HIGH, RDY_RANDOM, RDY_LOW} ready_mode_e;

  logic               clk = 1'b0;
  logic               arst_n;
  logic               stu_valid;
  stu_pkg::stu_beat_t stu_beat;
  logic               stu_ready;
  logic               rdp_valid;
  stu_pkg::stu_out_t  rdp;
  logic               rdp_ready = 1'b0;
  logic               rcp_valid;
  stu_pkg::stu_out_t  rcp;
  logic               rcp_ready = 1'b0;
  logic               rx_error;

  ready_mode_e        ready_mode = RDY_LOW;
  ready_mode_e        mode_now = RDY_LOW;  // mode seen at the edge
  string              test_name = "reset";
  logic               error_expected = 1'b0;
  stu_pkg::stu_out_t  rdp_exp[$];
  stu_pkg::stu_out_t  rcp_exp[$];
  stu_pkg::stu_out_t  rdp_want;
  stu_pkg::stu_out_t  rcp_want;
  int                 beats_sent = 0;
  int                 cycles = 0;

  stu_cntl u_dut (
    .clk       (clk),
    .arst_n    (arst_n),
    .stu_valid (stu_valid),
    .stu_beat  (stu_beat),
    .stu_ready (stu_ready),
    .rdp_valid (rdp_valid),
    .rdp       (rdp),
    .rdp_ready (rdp_ready),
    .rcp_valid (rcp_valid),
    .rcp       (rcp),
    .rcp_ready (rcp_ready),
    .rx_error  (rx_error)
  );

  always #10 clk = ~clk;

  // ------------------------------
  // error reporting
  task automatic stop_run();
    $display("test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_error(input string msg);
    $display("%s: %s", test_name, msg);
    stop_run();
  endtask

  task automatic fail_value(input string what, input stu_pkg::stu_out_t exp,
                            input stu_pkg::stu_out_t act);
    $display("Fail %s %s: expected %h actual %h", test_name, what, exp, act);
    stop_run();
  endtask

  // ------------------------------
  // beats and packets
  function automatic stu_pkg::stu_beat_t make_beat(input stu_pkg::stu_cntl_e cntl,
                                                   input stu_pkg::stu_type_e ptype);
    stu_pkg::stu_beat_t b;
    b.cntl  = cntl;
    b.ptype = ptype;
    b.data  = {$urandom(), $urandom()};
    b.oob   = $urandom();
    return b;
  endfunction

  // port view of a beat, tag is the low oob bits
  function automatic stu_pkg::stu_out_t expected_out(input stu_pkg::stu_beat_t b);
    stu_pkg::stu_out_t o;
    o.cntl = b.cntl;
    o.tag  = b.oob[stu_pkg::STU_TAG_W-1:0];
    o.data = b.data;
    return o;
  endfunction

  task automatic idle(input int n);
    repeat (n)
    begin
      @(posedge clk);
      #1;
    end
  endtask

  // entered and left 1 unit after a rising edge
  task automatic send_beat(input stu_pkg::stu_beat_t b, input bit expect_out);
    while (!stu_ready)
      idle(1);
    stu_valid = 1'b1;
    stu_beat  = b;
    beats_sent++;
    if (expect_out && b.ptype == stu_pkg::DATA)
      rdp_exp.push_back(expected_out(b));
    else if (expect_out)
      rcp_exp.push_back(expected_out(b));
    idle(1);
    stu_valid = 1'b0;
  endtask

  task automatic send_packet(input stu_pkg::stu_type_e ptype, input int len);
    stu_pkg::stu_cntl_e cntl;
    for (int i = 0; i < len; i++)
    begin
      if (len == 1)
        cntl = stu_pkg::SOM_EOM;
      else if (i == 0)
        cntl = stu_pkg::SOM;
      else if (i == len - 1)
        cntl = stu_pkg::EOM;
      else
        cntl = stu_pkg::MOM;
      send_beat(make_beat(cntl, ptype), 1'b1);
    end
  endtask

  task automatic wait_drained();
    while (rdp_exp.size() != 0 || rcp_exp.size() != 0)
      idle(1);
    idle(4);  // room for a stray extra pulse
  endtask

  // ------------------------------
  // processor readies
  always @(posedge clk)
  begin
    mode_now = ready_mode;
    #1;
    case (mode_now)
      RDY_HIGH:
      begin
        rdp_ready = 1'b1;
        rcp_ready = 1'b1;
      end
      RDY_RANDOM:
      begin
        rdp_ready = 1'($urandom % 2);
        rcp_ready = 1'($urandom % 2);
      end
      default:
      begin
        rdp_ready = 1'b0;
        rcp_ready = 1'b0;
      end
    endcase
  end

  // ------------------------------
  // scoreboards
  always @(posedge clk)
  begin
    if (arst_n && rdp_valid)
    begin
      if (rdp_exp.size() == 0)
        report_error("rdp_valid pulsed with no beat expected");
      else
      begin
        rdp_want = rdp_exp.pop_front();
        rdp_payload: assert (rdp == rdp_want)
          else fail_value("rdp payload", rdp_want, rdp);
      end
    end
  end

  always @(posedge clk)
  begin
    if (arst_n && rcp_valid)
    begin
      if (rcp_exp.size() == 0)
        report_error("rcp_valid pulsed with no beat expected");
      else
      begin
        rcp_want = rcp_exp.pop_front();
        rcp_payload: assert (rcp == rcp_want)
          else fail_value("rcp payload", rcp_want, rcp);
      end
    end
  end

  rdp_follows_ready: assert property (@(posedge clk) disable iff (!arst_n)
    rdp_valid |-> $past(rdp_ready))
    else report_error("rdp_valid without rdp_ready in the cycle before");

  rcp_follows_ready: assert property (@(posedge clk) disable iff (!arst_n)
    rcp_valid |-> $past(rcp_ready))
    else report_error("rcp_valid without rcp_ready in the cycle before");

  error_silences_ports: assert property (@(posedge clk) disable iff (!arst_n)
    rx_error |-> !rdp_valid && !rcp_valid)
    else report_error("a port pulsed valid while rx_error was high");

  error_sticky: assert property (@(posedge clk) disable iff (!arst_n)
    $past(rx_error) |-> rx_error)
    else report_error("rx_error dropped without reset");

  no_false_error: assert property (@(posedge clk) disable iff (!arst_n)
    !error_expected |-> !rx_error)
    else report_error("rx_error rose on well-framed traffic");

  // timeout, 40 cycles per sent beat plus 200
  always @(posedge clk)
  begin
    cycles++;
    if (cycles > 40 * beats_sent + 200)
      report_error("timeout, the DUT stopped delivering beats");
  end

  // ------------------------------
  // stimulus
  initial
  begin
    int n;
    void'($urandom(32'hcbe3b574));
    arst_n    = 1'b0;
    stu_valid = 1'b0;
    stu_beat  = '0;
    repeat (2) @(posedge clk);
    #1;
    reset_quiet: assert (!stu_ready && !rdp_valid && !rcp_valid && !rx_error)
      else report_error("outputs not low during reset");
    arst_n     = 1'b1;
    ready_mode = RDY_HIGH;

    test_name = "single_data";
    send_beat(make_beat(stu_pkg::SOM_EOM, stu_pkg::DATA), 1'b1);
    wait_drained();

    test_name = "control_packet";
    send_packet(stu_pkg::CONTROL, 4);
    wait_drained();

    test_name  = "random_mix";
    ready_mode = RDY_RANDOM;
    repeat (40)
    begin
      send_packet(stu_pkg::stu_type_e'($urandom % 2), 1 + $urandom % 4);
      idle($urandom % 3);
    end
    wait_drained();
    ready_mode = RDY_HIGH;

    test_name  = "backpressure";
    ready_mode = RDY_LOW;
    idle(2);
    n = 0;
    while (stu_ready && n < 16)
    begin
      send_beat(make_beat(stu_pkg::SOM_EOM, stu_pkg::stu_type_e'(n % 2)), 1'b1);
      n++;
    end
    ready_fell: assert (!stu_ready)
      else report_error("stu_ready stayed high with both processors stalled");
    idle(10);
    ready_held: assert (!stu_ready)
      else report_error("stu_ready rose while the processors were still stalled");
    ready_mode = RDY_HIGH;
    wait_drained();

    test_name      = "framing_error";
    error_expected = 1'b1;
    send_beat(make_beat(stu_pkg::MOM, stu_pkg::DATA), 1'b0);  // no packet open
    while (!rx_error)
      idle(1);
    send_beat(make_beat(stu_pkg::SOM_EOM, stu_pkg::DATA), 1'b0);
    idle(20);
    $display("test passed");
    $finish;
  end

endmodule

// ==== sim.f ====
stu_pkg.sv
stu_rx_fifo.sv
stu_rx_pipe.sv
stu_pkt_fsm.sv
stu_out_stage.sv
stu_cntl.sv
tb_stu_cntl.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the stu_cntl testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_stu_cntl -o sim_tb
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "test passed"; then
  exit 0
fi
exit 1
